// File: rtl/ovc_pkg.sv
`default_nettype none

package ovc_pkg;

   // ------------------------------
   // router sizes
   // ------------------------------

   // output VCs on this port; input VCs use the same count
   localparam int NUM_VCS = 4;
   localparam int VC_IDX_W = $clog2(NUM_VCS);

   // input ports of the router, local port included
   localparam int NUM_PORTS = 5;
   localparam int PORT_IDX_W = $clog2(NUM_PORTS);

   // ------------------------------
   // flow control
   // ------------------------------

   // downstream buffer slots per output VC, all free after reset
   localparam int BUFFER_DEPTH = 8;

   // must hold 0 to BUFFER_DEPTH inclusive
   localparam int CREDIT_W = $clog2(BUFFER_DEPTH + 1);

   // payload carried next to head, tail and VC number
   localparam int FLIT_DATA_W = 32;

   // ------------------------------
   // output VC state
   // ------------------------------

   // idle VCs are free for allocation; active ones belong to one input VC
   typedef enum logic
   {
      OVC_IDLE   = 1'b0,
      OVC_ACTIVE = 1'b1
   } ovc_state_t;

endpackage

`default_nettype wire

// File: rtl/ovc_state_fsm.sv
`default_nettype none
`timescale 1ns/10ps

module ovc_state_fsm
#(
   parameter int VC_ID = 0
)
(
   input  wire logic                          clk,
   input  wire logic                          reset,
   input  wire logic                          vc_gnt,
   input  wire logic [ovc_pkg::VC_IDX_W-1:0]   vc_gnt_vc,
   input  wire logic [ovc_pkg::PORT_IDX_W-1:0] vc_sel_ip,
   input  wire logic [ovc_pkg::VC_IDX_W-1:0]   vc_sel_ivc,
   input  wire logic                          stage_valid,
   input  wire logic [ovc_pkg::PORT_IDX_W-1:0] stage_ip,
   input  wire logic [ovc_pkg::VC_IDX_W-1:0]   stage_ivc,
   input  wire logic                          stage_tail,
   output logic                               flit_sel,
   output logic                               elig
);

   import ovc_pkg::*;

   ovc_state_t               state;
   logic [PORT_IDX_W-1:0]    alloc_ip;
   logic [VC_IDX_W-1:0]      alloc_ivc;
   logic                     gnt_hit;

   if (VC_ID >= NUM_VCS)
   begin : g_bad_vc_id
      $error("ovc_state_fsm: VC_ID out of range");
   end

   // allocation request addressed to this output VC
   assign gnt_hit = vc_gnt && (vc_gnt_vc == VC_IDX_W'(VC_ID));

   // ------------------------------
   // state register
   // ------------------------------
   always_ff @(posedge clk)
   begin
      if (reset)
         state <= OVC_IDLE;
      else if ((state == OVC_IDLE) && gnt_hit)
         state <= OVC_ACTIVE;
      else if ((state == OVC_ACTIVE) && flit_sel && stage_tail)
         state <= OVC_IDLE;
   end

   // owner of the VC, only meaningful while active
   always_ff @(posedge clk)
   begin
      if ((state == OVC_IDLE) && gnt_hit)
      begin
         alloc_ip  <= vc_sel_ip;
         alloc_ivc <= vc_sel_ivc;
      end
   end

   // staged flit belongs to the input VC holding this output VC
   assign flit_sel = (state == OVC_ACTIVE) && stage_valid &&
                     (stage_ip == alloc_ip) && (stage_ivc == alloc_ivc);

   assign elig = (state == OVC_IDLE);

endmodule

`default_nettype wire

// File: rtl/credit_counter.sv
`default_nettype none
`timescale 1ns/10ps

module credit_counter
#(
   parameter int VC_ID = 0
)
(
   input  wire logic                        clk,
   input  wire logic                        reset,
   input  wire logic                        credit_valid,
   input  wire logic [ovc_pkg::VC_IDX_W-1:0] credit_vc,
   input  wire logic                        flit_sel,
   output logic                             full,
   output logic                             almost_full,
   output logic                             error
);

   import ovc_pkg::*;

   logic                  credit_q;
   logic [CREDIT_W-1:0]   count;
   logic                  at_max;
   logic                  at_zero;

   // credit return is staged for one cycle before it is counted
   always_ff @(posedge clk)
   begin
      if (reset)
         credit_q <= 1'b0;
      else
         credit_q <= credit_valid && (credit_vc == VC_IDX_W'(VC_ID));
   end

   assign at_max  = (count == CREDIT_W'(BUFFER_DEPTH));
   assign at_zero = (count == '0);

   // ------------------------------
   // credit count
   // ------------------------------
   // a credit and a sent flit in the same cycle cancel out
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         count <= CREDIT_W'(BUFFER_DEPTH);
         error <= 1'b0;
      end
      else if (credit_q && !flit_sel)
      begin
         if (at_max)
            error <= 1'b1;
         else
            count <= count + 1'b1;
      end
      else if (flit_sel && !credit_q)
      begin
         // sent with no slot left downstream
         if (at_zero)
            error <= 1'b1;
         else
            count <= count - 1'b1;
      end
   end

   assign full        = at_zero;
   assign almost_full = (count == CREDIT_W'(1));

endmodule

`default_nettype wire

// File: rtl/channel_output.sv
`default_nettype none
`timescale 1ns/10ps

module channel_output
(
   input  wire logic                           clk,
   input  wire logic                           reset,
   input  wire logic                           sw_gnt,
   input  wire logic [ovc_pkg::PORT_IDX_W-1:0]  sw_sel_ip,
   input  wire logic [ovc_pkg::VC_IDX_W-1:0]    sw_sel_ivc,
   input  wire logic                           flit_head,
   input  wire logic                           flit_tail,
   input  wire logic [ovc_pkg::FLIT_DATA_W-1:0] flit_data,
   input  wire logic [ovc_pkg::NUM_VCS-1:0]     flit_sel_ovc,
   output logic                                stage_valid,
   output logic [ovc_pkg::PORT_IDX_W-1:0]       stage_ip,
   output logic [ovc_pkg::VC_IDX_W-1:0]         stage_ivc,
   output logic                                stage_tail,
   output logic                                channel_valid,
   output logic                                channel_head,
   output logic                                channel_tail,
   output logic [ovc_pkg::VC_IDX_W-1:0]         channel_vc,
   output logic [ovc_pkg::FLIT_DATA_W-1:0]      channel_data,
   output logic                                error
);

   import ovc_pkg::*;

   logic                     stage_head;
   logic [FLIT_DATA_W-1:0]   stage_data;
   logic [VC_IDX_W-1:0]      sel_vc;
   logic                     sent;

   // ------------------------------
   // flit staging
   // ------------------------------
   always_ff @(posedge clk)
   begin
      if (reset)
         stage_valid <= 1'b0;
      else
         stage_valid <= sw_gnt;
   end

   always_ff @(posedge clk)
   begin
      if (sw_gnt)
      begin
         stage_ip   <= sw_sel_ip;
         stage_ivc  <= sw_sel_ivc;
         stage_head <= flit_head;
         stage_tail <= flit_tail;
         stage_data <= flit_data;
      end
   end

   // one-hot select to VC number; at most one bit is ever set
   always_comb
   begin
      sel_vc = '0;
      for (int i = 0; i < NUM_VCS; i++)
      begin
         if (flit_sel_ovc[i])
            sel_vc = sel_vc | VC_IDX_W'(i);
      end
   end

   assign sent = |flit_sel_ovc;

   // ------------------------------
   // channel register
   // ------------------------------
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         channel_valid <= 1'b0;
         error         <= 1'b0;
      end
      else
      begin
         channel_valid <= sent;
         // nobody owns the staged flit, so it is dropped
         if (stage_valid && !sent)
            error <= 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (sent)
      begin
         channel_head <= stage_head;
         channel_tail <= stage_tail;
         channel_vc   <= sel_vc;
         channel_data <= stage_data;
      end
   end

endmodule

`default_nettype wire

// File: rtl/op_ctrl.sv
`default_nettype none
`timescale 1ns/10ps

module op_ctrl
(
   input  wire logic                           clk,
   input  wire logic                           reset,
   input  wire logic                           vc_gnt,
   input  wire logic [ovc_pkg::VC_IDX_W-1:0]    vc_gnt_vc,
   input  wire logic [ovc_pkg::PORT_IDX_W-1:0]  vc_sel_ip,
   input  wire logic [ovc_pkg::VC_IDX_W-1:0]    vc_sel_ivc,
   input  wire logic                           sw_gnt,
   input  wire logic [ovc_pkg::PORT_IDX_W-1:0]  sw_sel_ip,
   input  wire logic [ovc_pkg::VC_IDX_W-1:0]    sw_sel_ivc,
   input  wire logic                           flit_head,
   input  wire logic                           flit_tail,
   input  wire logic [ovc_pkg::FLIT_DATA_W-1:0] flit_data,
   input  wire logic                           credit_valid,
   input  wire logic [ovc_pkg::VC_IDX_W-1:0]    credit_vc,
   output logic [ovc_pkg::NUM_VCS-1:0]          elig_ovc,
   output logic [ovc_pkg::NUM_VCS-1:0]          full_ovc,
   output logic [ovc_pkg::NUM_VCS-1:0]          almost_full_ovc,
   output logic                                channel_valid,
   output logic                                channel_head,
   output logic                                channel_tail,
   output logic [ovc_pkg::VC_IDX_W-1:0]         channel_vc,
   output logic [ovc_pkg::FLIT_DATA_W-1:0]      channel_data,
   output logic                                error
);

   import ovc_pkg::*;

   logic                    stage_valid;
   logic [PORT_IDX_W-1:0]   stage_ip;
   logic [VC_IDX_W-1:0]     stage_ivc;
   logic                    stage_tail;
   logic [NUM_VCS-1:0]      flit_sel_ovc;
   logic [NUM_VCS-1:0]      credit_error;
   logic                    channel_error;

   // ------------------------------
   // per output VC control
   // ------------------------------
   for (genvar i = 0; i < NUM_VCS; i++)
   begin : g_vc
      ovc_state_fsm #(.VC_ID(i)) state_fsm_i
      (
         .clk         (clk),
         .reset       (reset),
         .vc_gnt      (vc_gnt),
         .vc_gnt_vc   (vc_gnt_vc),
         .vc_sel_ip   (vc_sel_ip),
         .vc_sel_ivc  (vc_sel_ivc),
         .stage_valid (stage_valid),
         .stage_ip    (stage_ip),
         .stage_ivc   (stage_ivc),
         .stage_tail  (stage_tail),
         .flit_sel    (flit_sel_ovc[i]),
         .elig        (elig_ovc[i])
      );

      credit_counter #(.VC_ID(i)) credit_i
      (
         .clk          (clk),
         .reset        (reset),
         .credit_valid (credit_valid),
         .credit_vc    (credit_vc),
         .flit_sel     (flit_sel_ovc[i]),
         .full         (full_ovc[i]),
         .almost_full  (almost_full_ovc[i]),
         .error        (credit_error[i])
      );
   end

   // staging and outgoing channel
   channel_output channel_output_i
   (
      .clk           (clk),
      .reset         (reset),
      .sw_gnt        (sw_gnt),
      .sw_sel_ip     (sw_sel_ip),
      .sw_sel_ivc    (sw_sel_ivc),
      .flit_head     (flit_head),
      .flit_tail     (flit_tail),
      .flit_data     (flit_data),
      .flit_sel_ovc  (flit_sel_ovc),
      .stage_valid   (stage_valid),
      .stage_ip      (stage_ip),
      .stage_ivc     (stage_ivc),
      .stage_tail    (stage_tail),
      .channel_valid (channel_valid),
      .channel_head  (channel_head),
      .channel_tail  (channel_tail),
      .channel_vc    (channel_vc),
      .channel_data  (channel_data),
      .error         (channel_error)
   );

   // every source is already sticky
   assign error = (|credit_error) || channel_error;

endmodule

`default_nettype wire

// File: tb/clk_gen.sv
`default_nettype none
`timescale 1ns/10ps

module clk_gen
#(
   parameter int HALF_PERIOD_NS = 2,
   parameter int RESET_CYCLES   = 16
)
(
   input  wire logic restart,
   output logic      clk,
   output logic      reset
);

   int rst_count = 0;

   initial
   begin
      clk = 1'b0;
      forever
         #(HALF_PERIOD_NS) clk = ~clk;
   end

   // reset stays high until RESET_CYCLES rising edges have passed
   always @(posedge clk)
   begin
      if (restart)
         rst_count <= 0;
      else if (rst_count < RESET_CYCLES)
         rst_count <= rst_count + 1;
   end

   assign reset = (rst_count < RESET_CYCLES);

endmodule

`default_nettype wire

// File: tb/op_ctrl_properties.sv
`default_nettype none
`timescale 1ns/10ps

module op_ctrl_properties
(
   input wire logic                          clk,
   input wire logic                          reset,
   input wire logic                          vc_gnt,
   input wire logic [ovc_pkg::VC_IDX_W-1:0]  vc_gnt_vc,
   input wire logic                          stage_valid,
   input wire logic [ovc_pkg::NUM_VCS-1:0]   flit_sel_ovc,
   input wire logic                          channel_valid,
   input wire logic                          channel_tail,
   input wire logic [ovc_pkg::VC_IDX_W-1:0]  channel_vc,
   input wire logic [ovc_pkg::NUM_VCS-1:0]   elig_ovc,
   input wire logic                          error
);

   import ovc_pkg::*;

   ovc_state_t           vc_state [NUM_VCS];
   logic [NUM_VCS-1:0]   active_mask;
   logic [NUM_VCS-1:0]   tail_out;

   // allocation as seen at the ports
   // a VC stays held until its tail flit is on the channel
   always_ff @(posedge clk)
   begin
      for (int i = 0; i < NUM_VCS; i++)
      begin
         if (reset)
            vc_state[i] <= OVC_IDLE;
         else if (vc_gnt && (vc_gnt_vc == VC_IDX_W'(i)))
            vc_state[i] <= OVC_ACTIVE;
         else if (tail_out[i])
            vc_state[i] <= OVC_IDLE;
      end
   end

   always_comb
   begin
      for (int i = 0; i < NUM_VCS; i++)
      begin
         active_mask[i] = (vc_state[i] == OVC_ACTIVE);
         tail_out[i]    = channel_valid && channel_tail && (channel_vc == VC_IDX_W'(i));
      end
   end

   sel_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(flit_sel_ovc))
      else $error("more than one output VC claims the staged flit");

   chan_follows_stage: assert property (@(posedge clk) disable iff (reset)
      stage_valid |=> (channel_valid || error))
      else $error("staged flit neither sent nor flagged one cycle later");

   chan_needs_stage: assert property (@(posedge clk) disable iff (reset)
      channel_valid |-> $past(stage_valid))
      else $error("channel valid without a staged flit one cycle earlier");

   // the FSM frees a VC in the cycle its tail shows on the channel
   alloc_not_elig: assert property (@(posedge clk) disable iff (reset)
      (active_mask & elig_ovc & ~tail_out) == '0)
      else $error("allocated output VC shown as eligible");

endmodule

bind op_ctrl op_ctrl_properties op_ctrl_properties_i
(
   .clk           (clk),
   .reset         (reset),
   .vc_gnt        (vc_gnt),
   .vc_gnt_vc     (vc_gnt_vc),
   .stage_valid   (stage_valid),
   .flit_sel_ovc  (flit_sel_ovc),
   .channel_valid (channel_valid),
   .channel_tail  (channel_tail),
   .channel_vc    (channel_vc),
   .elig_ovc      (elig_ovc),
   .error         (error)
);

`default_nettype wire

// File: tb/op_ctrl_tb.sv
`default_nettype none
`timescale 1ns/10ps

module op_ctrl_tb;

   import ovc_pkg::*;

   localparam logic [31:0] LFSR_SEED = 32'h5a873301;
   localparam int WAIT_LIMIT = 20;
   localparam int SIM_LIMIT_NS = 5000;
   localparam int NUM_ROWS = 10;
   localparam int NUM_TESTS = 5;

   typedef enum {OP_IDLE, OP_ALLOC, OP_SEND, OP_CREDIT, OP_RESET} op_t;

   typedef struct {
      int                      test;
      op_t                     op;
      logic [VC_IDX_W-1:0]     vc;
      logic [PORT_IDX_W-1:0]   port;
      logic [VC_IDX_W-1:0]     ivc;
      logic                    head;
      logic                    tail;
      int                      reps;
      logic                    exp_chan;
      logic                    exp_err;
   } row_t;

   logic clk, reset, restart;
   logic vc_gnt, sw_gnt, flit_head, flit_tail, credit_valid;
   logic [VC_IDX_W-1:0] vc_gnt_vc, vc_sel_ivc, sw_sel_ivc, credit_vc, channel_vc;
   logic [PORT_IDX_W-1:0] vc_sel_ip, sw_sel_ip;
   logic [FLIT_DATA_W-1:0] flit_data, channel_data;
   logic [NUM_VCS-1:0] elig_ovc, full_ovc, almost_full_ovc;
   logic channel_valid, channel_head, channel_tail, error;

   // reference model state
   int credits [NUM_VCS];
   logic [NUM_VCS-1:0] alloc_act, m_elig, m_full, m_af, old_elig, old_full, old_af;
   logic [PORT_IDX_W-1:0] alloc_ip [NUM_VCS];
   logic [VC_IDX_W-1:0] alloc_ivc [NUM_VCS];
   logic exp_error, old_err, exp_chan, exp_head, exp_tail;
   logic [VC_IDX_W-1:0] exp_vc;
   logic [FLIT_DATA_W-1:0] exp_data;
   logic [31:0] lfsr_state;

   row_t rows [NUM_ROWS];
   string test_names [NUM_TESTS];
   int errors, test_errors, tests_passed, tests_failed;

   clk_gen clk_gen_i (.restart(restart), .clk(clk), .reset(reset));

   op_ctrl op_ctrl_i
   (
      .clk(clk), .reset(reset),
      .vc_gnt(vc_gnt), .vc_gnt_vc(vc_gnt_vc), .vc_sel_ip(vc_sel_ip), .vc_sel_ivc(vc_sel_ivc),
      .sw_gnt(sw_gnt), .sw_sel_ip(sw_sel_ip), .sw_sel_ivc(sw_sel_ivc),
      .flit_head(flit_head), .flit_tail(flit_tail), .flit_data(flit_data),
      .credit_valid(credit_valid), .credit_vc(credit_vc),
      .elig_ovc(elig_ovc), .full_ovc(full_ovc), .almost_full_ovc(almost_full_ovc),
      .channel_valid(channel_valid), .channel_head(channel_head), .channel_tail(channel_tail),
      .channel_vc(channel_vc), .channel_data(channel_data), .error(error)
   );

   task automatic load_table();
      // test, op, vc, port, ivc, head, tail, reps, exp_chan, exp_err
      rows[0] = '{1, OP_IDLE,   0, 0, 0, 0, 0, 1, 0, 0};
      rows[1] = '{2, OP_ALLOC,  2, 3, 1, 0, 0, 1, 0, 0};
      rows[2] = '{2, OP_SEND,   2, 3, 1, 1, 1, 1, 1, 0};
      rows[3] = '{3, OP_ALLOC,  0, 1, 0, 0, 0, 1, 0, 0};
      rows[4] = '{3, OP_SEND,   0, 1, 0, 1, 0, 7, 1, 0};
      rows[5] = '{3, OP_SEND,   0, 1, 0, 0, 0, 1, 1, 0};
      rows[6] = '{3, OP_CREDIT, 0, 0, 0, 0, 0, 1, 0, 0};
      rows[7] = '{4, OP_SEND,   0, 4, 3, 1, 1, 1, 0, 1};
      rows[8] = '{5, OP_RESET,  0, 0, 0, 0, 0, 1, 0, 0};
      rows[9] = '{5, OP_CREDIT, 1, 0, 0, 0, 0, 1, 0, 1};
      test_names = '{"reset state", "single-flit packet", "credit flags",
                     "unmatched flit", "credit overflow"};
   endtask

   // Galois LFSR, x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      if (s[0])
         return (s >> 1) ^ 32'h80200003;
      else
         return s >> 1;
   endfunction

   function automatic logic [FLIT_DATA_W-1:0] next_data();
      logic [FLIT_DATA_W-1:0] d;
      d = '0;
      for (int b = 0; b < FLIT_DATA_W; b++)
      begin
         lfsr_state = lfsr_step(lfsr_state);
         d = {d[FLIT_DATA_W-2:0], lfsr_state[0]};
      end
      return d;
   endfunction

   // ------------------------------
   // reference model
   // ------------------------------
   function automatic void refresh_flags();
      for (int i = 0; i < NUM_VCS; i++)
      begin
         m_elig[i] = !alloc_act[i];
         m_full[i] = (credits[i] == 0);
         m_af[i]   = (credits[i] == 1);
      end
   endfunction

   function automatic void reset_model();
      for (int i = 0; i < NUM_VCS; i++)
         credits[i] = BUFFER_DEPTH;
      alloc_act = '0;
      exp_error = 1'b0;
      refresh_flags();
   endfunction

   task automatic update_model(input row_t r, input int rep);
      int owner;
      owner = -1;
      old_elig = m_elig;
      old_full = m_full;
      old_af = m_af;
      old_err = exp_error;
      exp_chan = 1'b0;
      case (r.op)
         OP_ALLOC:
            if (!alloc_act[r.vc])
            begin
               alloc_act[r.vc] = 1'b1;
               alloc_ip[r.vc] = r.port;
               alloc_ivc[r.vc] = r.ivc;
            end
         OP_SEND:
         begin
            exp_chan = r.exp_chan;
            exp_vc = r.vc;
            exp_data = next_data();
            exp_head = r.head && (rep == 0);
            exp_tail = r.tail && (rep == r.reps - 1);
            for (int i = 0; i < NUM_VCS; i++)
               if (alloc_act[i] && (alloc_ip[i] == r.port) && (alloc_ivc[i] == r.ivc))
                  owner = i;
            if (owner >= 0)
            begin
               if (credits[owner] > 0)
                  credits[owner]--;
               if (exp_tail)
                  alloc_act[owner] = 1'b0;
            end
         end
         OP_CREDIT:
            if (credits[r.vc] < BUFFER_DEPTH)
               credits[r.vc]++;
         OP_RESET:
            reset_model();
         default: ;
      endcase
      exp_error = r.exp_err;
      refresh_flags();
   endtask

   // ------------------------------
   // checks
   // ------------------------------
   task automatic value_error(input string what, input logic [31:0] got, input logic [31:0] exp);
      $display("** Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
      errors++;
      test_errors++;
   endtask

   task automatic plain_error(input string msg);
      $display("at %0t ns: %s", $time, msg);
      errors++;
      test_errors++;
   endtask

   task automatic check_outputs(input logic [NUM_VCS-1:0] e_elig, input logic [NUM_VCS-1:0] e_full,
                                input logic [NUM_VCS-1:0] e_af, input logic e_err);
      assert (elig_ovc == e_elig) else value_error("elig_ovc", 32'(elig_ovc), 32'(e_elig));
      assert (full_ovc == e_full) else value_error("full_ovc", 32'(full_ovc), 32'(e_full));
      assert (almost_full_ovc == e_af)
         else value_error("almost_full_ovc", 32'(almost_full_ovc), 32'(e_af));
      assert (error == e_err) else value_error("error", 32'(error), 32'(e_err));
   endtask

   task automatic check_channel();
      assert (exp_chan) else plain_error("a flit left on the channel where none was expected");
      if (exp_chan)
      begin
         assert (channel_vc == exp_vc) else value_error("channel_vc", 32'(channel_vc), 32'(exp_vc));
         assert (channel_data == exp_data) else value_error("channel_data", channel_data, exp_data);
         assert (channel_head == exp_head)
            else value_error("channel_head", 32'(channel_head), 32'(exp_head));
         assert (channel_tail == exp_tail)
            else value_error("channel_tail", 32'(channel_tail), 32'(exp_tail));
      end
   endtask

   // outputs keep their old values before lat cycles and reach the model at lat
   task automatic wait_outputs(input int lat);
      int cyc;
      int chan_cyc;
      logic done;
      cyc = 0;
      chan_cyc = 0;
      done = 1'b0;
      while (!done && (cyc < WAIT_LIMIT))
      begin
         @(negedge clk);
         cyc++;
         if (channel_valid && (chan_cyc == 0))
         begin
            chan_cyc = cyc;
            check_channel();
         end
         if (cyc < lat)
            check_outputs(old_elig, old_full, old_af, old_err);
         else
            done = (elig_ovc == m_elig) && (full_ovc == m_full) &&
                   (almost_full_ovc == m_af) && (error == exp_error);
      end
      if (!done)
         plain_error("outputs never reached the expected state");
      check_outputs(m_elig, m_full, m_af, exp_error);
      assert (cyc == lat) else value_error("settling cycles", 32'(cyc), 32'(lat));
      assert (chan_cyc == (exp_chan ? 2 : 0))
         else value_error("channel_valid cycle", 32'(chan_cyc), exp_chan ? 32'd2 : 32'd0);
   endtask

   task automatic wait_reset_done();
      int cyc;
      cyc = 0;
      do
      begin
         @(negedge clk);
         cyc++;
      end
      while (reset && (cyc < 2 * WAIT_LIMIT));
      if (reset)
         plain_error("reset never deasserted");
      assert (!channel_valid) else value_error("channel_valid", 32'(channel_valid), 32'd0);
      check_outputs(m_elig, m_full, m_af, exp_error);
   endtask

   // ------------------------------
   // stimulus
   // ------------------------------
   task automatic drive_op(input row_t r);
      @(posedge clk);
      case (r.op)
         OP_ALLOC:
         begin
            vc_gnt     <= 1'b1;
            vc_gnt_vc  <= r.vc;
            vc_sel_ip  <= r.port;
            vc_sel_ivc <= r.ivc;
         end
         OP_SEND:
         begin
            sw_gnt     <= 1'b1;
            sw_sel_ip  <= r.port;
            sw_sel_ivc <= r.ivc;
            flit_head  <= exp_head;
            flit_tail  <= exp_tail;
            flit_data  <= exp_data;
         end
         OP_CREDIT:
         begin
            credit_valid <= 1'b1;
            credit_vc    <= r.vc;
         end
         OP_RESET:
            restart <= 1'b1;
         default: ;
      endcase
      @(posedge clk);
      vc_gnt       <= 1'b0;
      sw_gnt       <= 1'b0;
      credit_valid <= 1'b0;
      restart      <= 1'b0;
   endtask

   task automatic run_row(input row_t r);
      for (int rep = 0; rep < r.reps; rep++)
      begin
         update_model(r, rep);
         drive_op(r);
         if (r.op == OP_RESET)
            wait_reset_done();
         else if ((r.op == OP_SEND) || (r.op == OP_CREDIT))
            wait_outputs(2);
         else
            wait_outputs(1);
      end
   endtask

   task automatic report_test(input int t);
      if (test_errors == 0)
      begin
         tests_passed++;
         $display("test %0d %s: pass", t, test_names[t - 1]);
      end
      else
      begin
         tests_failed++;
         $display("test %0d %s: %0d errors", t, test_names[t - 1], test_errors);
      end
      test_errors = 0;
   endtask

   initial
   begin
      restart = 1'b0;
      vc_gnt = 1'b0;
      vc_gnt_vc = '0;
      vc_sel_ip = '0;
      vc_sel_ivc = '0;
      sw_gnt = 1'b0;
      sw_sel_ip = '0;
      sw_sel_ivc = '0;
      flit_head = 1'b0;
      flit_tail = 1'b0;
      flit_data = '0;
      credit_valid = 1'b0;
      credit_vc = '0;
      errors = 0;
      test_errors = 0;
      tests_passed = 0;
      tests_failed = 0;
      lfsr_state = LFSR_SEED;
      load_table();
      reset_model();
      wait_reset_done();
      for (int i = 0; i < NUM_ROWS; i++)
      begin
         if ((i > 0) && (rows[i].test != rows[i - 1].test))
            report_test(rows[i - 1].test);
         run_row(rows[i]);
      end
      report_test(rows[NUM_ROWS - 1].test);
      $display("tests %0d, passed %0d, failed %0d, errors %0d",
               tests_passed + tests_failed, tests_passed, tests_failed, errors);
      if (errors == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

   // watchdog for the whole run
   initial
   begin
      #(SIM_LIMIT_NS);
      $display("simulation ran past its time limit of %0d ns", SIM_LIMIT_NS);
      $display("Test FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: all.f
rtl/ovc_pkg.sv
rtl/ovc_state_fsm.sv
rtl/credit_counter.sv
rtl/channel_output.sv
rtl/op_ctrl.sv
tb/clk_gen.sv
tb/op_ctrl_properties.sv
tb/op_ctrl_tb.sv

// File: Makefile
# Verilator flow for the output-port controller

SIM := obj_dir/Vop_ctrl_tb

.PHONY: all run lint clean

all: run

$(SIM): all.f rtl/*.sv tb/*.sv
	verilator --binary --timing --assert --timescale 1ns/10ps -f all.f --top-module op_ctrl_tb

# the run passes only if the pass line shows up in the output
run: $(SIM)
	$(SIM) | tee /dev/stderr | grep -x "Test OK" > /dev/null

lint:
	verilator --lint-only -Wall --timescale 1ns/10ps rtl/ovc_pkg.sv rtl/ovc_state_fsm.sv \
		rtl/credit_counter.sv rtl/channel_output.sv rtl/op_ctrl.sv --top-module op_ctrl

clean:
	rm -rf obj_dir
